/* source/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////
    localparam int data_width      = 32;
    localparam int imem_addr_width = 6;   // 64 words
    localparam int reg_addr_width  = 5;

    typedef logic [data_width-1:0]     word_t;
    typedef logic [reg_addr_width-1:0] reg_addr_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_lui
    } alu_op_t;

    //////////////////////////////////////////////////
    // encodings
    //////////////////////////////////////////////////
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_lui     = 6'h0f;

    localparam logic [5:0] fn_break   = 6'h0d;   // test done
    localparam logic [5:0] fn_addu    = 6'h21;
    localparam logic [5:0] fn_subu    = 6'h23;
    localparam logic [5:0] fn_and     = 6'h24;
    localparam logic [5:0] fn_or      = 6'h25;
    localparam logic [5:0] fn_xor     = 6'h26;
    localparam logic [5:0] fn_slt     = 6'h2a;

    localparam logic [1:0] br_none = 2'd0;
    localparam logic [1:0] br_beq  = 2'd1;
    localparam logic [1:0] br_bne  = 2'd2;
    localparam logic [1:0] br_jump = 2'd3;

    //////////////////////////////////////////////////
    // stage payloads
    //////////////////////////////////////////////////
    typedef struct packed {
        word_t                      inst;
        logic [imem_addr_width-1:0] pc;     // word index
    } fetch_payload_t;

    typedef struct packed {
        alu_op_t    alu_op;
        word_t      operand_a;
        word_t      operand_b;
        word_t      compare_b;
        reg_addr_t  dest;
        logic       reg_write;
        logic [1:0] branch_kind;
        word_t      branch_target;
        logic       done;
    } decode_payload_t;

    typedef struct packed {
        reg_addr_t dest;   // zero when nothing to write
        word_t     result;
        logic      done;
    } writeback_payload_t;

endpackage

`default_nettype wire

/* source/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 run,
    input  logic                                 stall,
    input  logic                                 redirect,
    input  mips_pkg::word_t                      redirect_pc,
    input  logic                                 load_valid,
    output logic                                 load_ready,
    input  logic [mips_pkg::imem_addr_width-1:0] load_addr,
    input  mips_pkg::word_t                      load_data,
    output mips_pkg::word_t                      pc,
    output mips_pkg::word_t                      inst,
    output logic                                 fetch_valid
);
    import mips_pkg::*;

    word_t imem [2**imem_addr_width];

    assign load_ready  = ~run;   // loading only while halted
    assign fetch_valid = run;
    assign inst        = imem[pc[imem_addr_width+1:2]];

    always_ff @(posedge clk)
    begin
        if (load_valid && load_ready)
            imem[load_addr] <= load_data;
    end

    // taken branch beats stall
    always_ff @(posedge clk)
    begin
        if (rst)
            pc <= '0;
        else if (redirect)
            pc <= redirect_pc;
        else if (run && !stall)
            pc <= pc + 32'd4;
    end

endmodule

`default_nettype wire

/* source/decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  mips_pkg::word_t     inst,
    output mips_pkg::reg_addr_t rs_addr,
    output mips_pkg::reg_addr_t rt_addr,
    output mips_pkg::reg_addr_t dest,
    output logic                reg_write,
    output mips_pkg::alu_op_t   alu_op,
    output logic                use_imm,
    output mips_pkg::word_t     imm,
    output logic [1:0]          branch_kind,
    output mips_pkg::word_t     branch_target,
    input  mips_pkg::word_t     pc,
    output logic                done
);
    import mips_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    word_t      pc_plus4;
    word_t      sext_imm;
    word_t      zext_imm;

    assign opcode   = inst[31:26];
    assign funct    = inst[5:0];
    assign rs_addr  = inst[25:21];
    assign rt_addr  = inst[20:16];
    assign pc_plus4 = pc + 32'd4;
    assign sext_imm = {{16{inst[15]}}, inst[15:0]};
    assign zext_imm = {16'h0000, inst[15:0]};

    // no delay slot, offsets count from pc+4
    assign branch_target = (opcode == op_j) ? {pc_plus4[31:28], inst[25:0], 2'b00}
                                            : pc_plus4 + {sext_imm[29:0], 2'b00};

    always_comb
    begin
        dest        = inst[20:16];   // i-type default
        reg_write   = 1'b0;
        alu_op      = alu_add;
        use_imm     = 1'b0;
        imm         = sext_imm;
        branch_kind = br_none;
        done        = 1'b0;
        case (opcode)
            op_special:
            begin
                dest      = inst[15:11];
                reg_write = 1'b1;
                case (funct)
                    fn_addu: alu_op = alu_add;
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_xor:  alu_op = alu_xor;
                    fn_slt:  alu_op = alu_slt;
                    fn_break:
                    begin
                        reg_write = 1'b0;
                        done      = 1'b1;
                    end
                    default: reg_write = 1'b0;
                endcase
            end
            op_addiu:
            begin
                reg_write = 1'b1;
                use_imm   = 1'b1;
            end
            op_andi:
            begin
                reg_write = 1'b1;
                use_imm   = 1'b1;
                imm       = zext_imm;
                alu_op    = alu_and;
            end
            op_ori:
            begin
                reg_write = 1'b1;
                use_imm   = 1'b1;
                imm       = zext_imm;
                alu_op    = alu_or;
            end
            op_lui:
            begin
                reg_write = 1'b1;
                use_imm   = 1'b1;
                imm       = zext_imm;
                alu_op    = alu_lui;
            end
            op_beq:  branch_kind = br_beq;
            op_bne:  branch_kind = br_bne;
            op_j:    branch_kind = br_jump;
            default: ;                 // unknown word, no-op
        endcase
        if (!reg_write)
            dest = '0;
    end

endmodule

`default_nettype wire

/* source/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic                clk,
    input  logic                rst,
    input  mips_pkg::reg_addr_t rs_addr,
    input  mips_pkg::reg_addr_t rt_addr,
    output mips_pkg::word_t     rs_data,
    output mips_pkg::word_t     rt_data,
    input  logic                write_enable,
    input  mips_pkg::reg_addr_t write_addr,
    input  mips_pkg::word_t     write_data
);
    import mips_pkg::*;

    word_t regs [2**reg_addr_width];

    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < 2**reg_addr_width; i++)
                regs[i] <= '0;
        end
        else if (write_enable && write_addr != '0)   // $zero stays zero
            regs[write_addr] <= write_data;
    end

endmodule

`default_nettype wire

/* source/forwarding_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module forwarding_unit (
    input  mips_pkg::reg_addr_t rs_addr,
    input  mips_pkg::reg_addr_t rt_addr,
    input  mips_pkg::word_t     rs_data,
    input  mips_pkg::word_t     rt_data,
    input  logic                exec_write,
    input  logic                wb_write,
    input  mips_pkg::reg_addr_t exec_dest,
    input  mips_pkg::reg_addr_t wb_dest,
    input  mips_pkg::word_t     exec_result,
    input  mips_pkg::word_t     wb_result,
    output mips_pkg::word_t     rs_value,
    output mips_pkg::word_t     rt_value
);
    import mips_pkg::*;

    // newest producer wins
    function automatic word_t pick(input reg_addr_t addr, input word_t file_value);
        if (addr == '0)
            return file_value;
        if (exec_write && exec_dest == addr)
            return exec_result;
        if (wb_write && wb_dest == addr)
            return wb_result;
        return file_value;
    endfunction

    always_comb
    begin
        rs_value = pick(rs_addr, rs_data);
        rt_value = pick(rt_addr, rt_data);
    end

endmodule

`default_nettype wire

/* source/execution.sv */
`timescale 1ns/1ps
`default_nettype none

module execution (
    input  mips_pkg::alu_op_t alu_op,
    input  mips_pkg::word_t   operand_a,
    input  mips_pkg::word_t   operand_b,
    input  mips_pkg::word_t   compare_b,
    input  logic [1:0]        branch_kind,
    input  mips_pkg::word_t   branch_target,
    input  logic              stage_valid,
    output mips_pkg::word_t   result,
    output logic              take_branch,
    output mips_pkg::word_t   target
);
    import mips_pkg::*;

    logic equal;

    always_comb
    begin
        case (alu_op)
            alu_add: result = operand_a + operand_b;
            alu_sub: result = operand_a - operand_b;
            alu_and: result = operand_a & operand_b;
            alu_or:  result = operand_a | operand_b;
            alu_xor: result = operand_a ^ operand_b;
            alu_slt: result = {{(data_width-1){1'b0}}, $signed(operand_a) < $signed(operand_b)};
            alu_lui: result = {operand_b[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

    assign equal = (operand_a == compare_b);   // rs vs rt

    always_comb
    begin
        case (branch_kind)
            br_beq:  take_branch = stage_valid && equal;
            br_bne:  take_branch = stage_valid && !equal;
            br_jump: take_branch = stage_valid;
            default: take_branch = 1'b0;
        endcase
    end

    assign target = branch_target;

endmodule

`default_nettype wire

/* source/pipeline_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeline_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     stall,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_payload,
    output logic     out_valid,
    output payload_t out_payload
);

    always_ff @(posedge clk)
    begin
        if (rst || flush)
            out_valid <= 1'b0;   // bubble
        else if (!stall)
            out_valid <= in_valid;
    end

    always_ff @(posedge clk)
    begin
        if (!stall)
            out_payload <= in_payload;
    end

endmodule

`default_nettype wire

/* source/pipeline_control.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeline_control (
    input  logic clk,
    input  logic rst,
    input  logic retire_valid,
    input  logic retire_ready,
    input  logic take_branch,
    input  logic wb_done,
    output logic stall,
    output logic flush_young,
    output logic done
);

    // freeze everything once the test is over
    assign stall = (retire_valid && !retire_ready) || done;

    // a stalled branch waits in execute until it can move on
    assign flush_young = take_branch && !stall;

    always_ff @(posedge clk)
    begin
        if (rst)
            done <= 1'b0;
        else if (wb_done)
            done <= 1'b1;   // sticky
    end

endmodule

`default_nettype wire

/* source/mips_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_cpu (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 run,
    input  logic                                 load_valid,
    output logic                                 load_ready,
    input  logic [mips_pkg::imem_addr_width-1:0] load_addr,
    input  mips_pkg::word_t                      load_data,
    output logic                                 retire_valid,
    input  logic                                 retire_ready,
    output mips_pkg::reg_addr_t                  retire_reg,
    output mips_pkg::word_t                      retire_data,
    output logic                                 done
);
    import mips_pkg::*;

    logic stall, flush_young;

    word_t fetch_pc, fetch_inst;
    logic  fetch_valid;

    fetch_payload_t fd_in, fd_out;
    logic           fd_valid;

    reg_addr_t  dec_rs_addr, dec_rt_addr, dec_dest;
    logic       dec_reg_write, dec_use_imm, dec_done;
    alu_op_t    dec_alu_op;
    logic [1:0] dec_branch_kind;
    word_t      dec_imm, dec_branch_target, dec_pc;

    word_t rf_rs_data, rf_rt_data, fwd_rs_value, fwd_rt_value;

    decode_payload_t de_in, de_out;
    logic            de_valid;

    word_t exec_result, exec_target;
    logic  exec_take_branch, exec_write;

    writeback_payload_t ew_in, ew_out;
    logic               ew_valid, wb_done;

    //////////////////////////////////////////////////
    // fetch
    //////////////////////////////////////////////////
    fetch_unit fetch (
        .clk(clk), .rst(rst), .run(run), .stall(stall),
        .redirect(flush_young), .redirect_pc(exec_target),
        .load_valid(load_valid), .load_ready(load_ready),
        .load_addr(load_addr), .load_data(load_data),
        .pc(fetch_pc), .inst(fetch_inst), .fetch_valid(fetch_valid));

    assign fd_in = '{inst: fetch_inst, pc: fetch_pc[imem_addr_width+1:2]};

    pipeline_stage #(.payload_t(fetch_payload_t)) fetch2dec (
        .clk(clk), .rst(rst), .stall(stall), .flush(flush_young),
        .in_valid(fetch_valid), .in_payload(fd_in),
        .out_valid(fd_valid), .out_payload(fd_out));

    //////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////
    assign dec_pc = {{(data_width-imem_addr_width-2){1'b0}}, fd_out.pc, 2'b00};

    decoder decode (
        .inst(fd_out.inst), .rs_addr(dec_rs_addr), .rt_addr(dec_rt_addr),
        .dest(dec_dest), .reg_write(dec_reg_write), .alu_op(dec_alu_op),
        .use_imm(dec_use_imm), .imm(dec_imm), .branch_kind(dec_branch_kind),
        .branch_target(dec_branch_target), .pc(dec_pc), .done(dec_done));

    register_file regfile (
        .clk(clk), .rst(rst),
        .rs_addr(dec_rs_addr), .rt_addr(dec_rt_addr),
        .rs_data(rf_rs_data), .rt_data(rf_rt_data),
        .write_enable(retire_valid && retire_ready),
        .write_addr(ew_out.dest), .write_data(ew_out.result));

    forwarding_unit forward (
        .rs_addr(dec_rs_addr), .rt_addr(dec_rt_addr),
        .rs_data(rf_rs_data), .rt_data(rf_rt_data),
        .exec_write(exec_write), .wb_write(retire_valid),
        .exec_dest(de_out.dest), .wb_dest(ew_out.dest),
        .exec_result(exec_result), .wb_result(ew_out.result),
        .rs_value(fwd_rs_value), .rt_value(fwd_rt_value));

    assign de_in = '{alu_op: dec_alu_op,
                     operand_a: fwd_rs_value,
                     operand_b: dec_use_imm ? dec_imm : fwd_rt_value,
                     compare_b: fwd_rt_value,
                     dest: dec_dest,
                     reg_write: dec_reg_write,
                     branch_kind: dec_branch_kind,
                     branch_target: dec_branch_target,
                     done: dec_done};

    pipeline_stage #(.payload_t(decode_payload_t)) dec2exec (
        .clk(clk), .rst(rst), .stall(stall), .flush(flush_young),
        .in_valid(fd_valid), .in_payload(de_in),
        .out_valid(de_valid), .out_payload(de_out));

    //////////////////////////////////////////////////
    // execute and writeback
    //////////////////////////////////////////////////
    execution exe (
        .alu_op(de_out.alu_op), .operand_a(de_out.operand_a),
        .operand_b(de_out.operand_b), .compare_b(de_out.compare_b),
        .branch_kind(de_out.branch_kind), .branch_target(de_out.branch_target),
        .stage_valid(de_valid), .result(exec_result),
        .take_branch(exec_take_branch), .target(exec_target));

    assign exec_write = de_valid && de_out.reg_write;
    assign ew_in      = '{dest: de_out.dest, result: exec_result, done: de_out.done};

    pipeline_stage #(.payload_t(writeback_payload_t)) exec2wb (
        .clk(clk), .rst(rst), .stall(stall), .flush(1'b0),
        .in_valid(de_valid), .in_payload(ew_in),
        .out_valid(ew_valid), .out_payload(ew_out));

    // anything behind the done instruction never retires
    assign retire_valid = ew_valid && (ew_out.dest != '0) && !done;
    assign retire_reg   = ew_out.dest;
    assign retire_data  = ew_out.result;
    assign wb_done      = ew_valid && ew_out.done;

    pipeline_control control (
        .clk(clk), .rst(rst),
        .retire_valid(retire_valid), .retire_ready(retire_ready),
        .take_branch(exec_take_branch), .wb_done(wb_done),
        .stall(stall), .flush_young(flush_young), .done(done));

endmodule

`default_nettype wire

/* tb/mips_cpu_props.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_props (
    input logic                clk,
    input logic                rst,
    input logic                retire_valid,
    input logic                retire_ready,
    input mips_pkg::reg_addr_t retire_reg,
    input mips_pkg::word_t     retire_data,
    input logic                done
);

    // a waiting retire keeps its register and value
    retire_hold: assert property (@(posedge clk) disable iff (rst)
        (retire_valid && !retire_ready) |=>
            (retire_valid && $stable(retire_reg) && $stable(retire_data)))
        else $error("retire port changed while waiting for retire_ready");

    done_sticky: assert property (@(posedge clk) disable iff (rst)
        done |=> done)
        else $error("done fell without reset");

    // $zero writes stay inside the core
    no_zero_retire: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> (retire_reg != '0))
        else $error("retire_valid high with register 0");

endmodule

`default_nettype wire

/* tb/tb_mips_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mips_cpu;
    import mips_pkg::*;

    localparam int imem_words   = 2**imem_addr_width;
    localparam int load_timeout = 20;
    localparam int run_timeout  = 2000;
    localparam int model_limit  = 1000;
    localparam int hold_cycles  = 8;

    typedef logic [reg_addr_width+data_width-1:0] entry_t;   // {reg, value}
    typedef entry_t entry_q_t[$];

    logic                       clk;
    logic                       rst;
    logic                       run;
    logic                       load_valid;
    logic                       load_ready;
    logic [imem_addr_width-1:0] load_addr;
    word_t                      load_data;
    logic                       retire_valid;
    logic                       retire_ready;
    reg_addr_t                  retire_reg;
    word_t                      retire_data;
    logic                       done;

    word_t       prog_mem [imem_words];
    entry_q_t    expected_q;
    entry_q_t    actual_q;
    entry_q_t    reference_q;
    logic [31:0] rng_state;
    int          check_count;
    int          mismatch_count;
    int          other_error_count;

    mips_cpu mips_cpu_inst (
        .clk(clk), .rst(rst), .run(run),
        .load_valid(load_valid), .load_ready(load_ready),
        .load_addr(load_addr), .load_data(load_data),
        .retire_valid(retire_valid), .retire_ready(retire_ready),
        .retire_reg(retire_reg), .retire_data(retire_data), .done(done));

    bind mips_cpu mips_cpu_props props (
        .clk(clk), .rst(rst), .retire_valid(retire_valid),
        .retire_ready(retire_ready), .retire_reg(retire_reg),
        .retire_data(retire_data), .done(done));

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic word_t r_format(input logic [5:0] funct, input reg_addr_t rd,
                                       input reg_addr_t rs, input reg_addr_t rt);
        return {op_special, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic word_t i_format(input logic [5:0] op, input reg_addr_t rs,
                                       input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t j_format(input logic [25:0] index);
        return {op_j, index};
    endfunction

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        check_count++;
        if (actual !== expected)
        begin
            mismatch_count++;
            $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // unknown opcode tagged with its own address
    task automatic clear_program();
        int i;
        for (i = 0; i < imem_words; i++)
            prog_mem[i] = {6'h3f, {(26-imem_addr_width){1'b0}}, i[imem_addr_width-1:0]};
    endtask

    //////////////////////////////////////////////////
    // ISA model
    //////////////////////////////////////////////////
    task automatic run_model(input string name);
        word_t                      regs [32];
        logic [imem_addr_width-1:0] pc;
        word_t                      inst;
        word_t                      a;
        word_t                      b;
        word_t                      value;
        reg_addr_t                  dest;
        bit                         stop;
        int                         steps;
        expected_q.delete();
        foreach (regs[i])
            regs[i] = '0;
        pc    = '0;
        stop  = 1'b0;
        steps = 0;
        while (!stop && steps < model_limit)
        begin
            inst  = prog_mem[pc];
            a     = regs[inst[25:21]];
            b     = regs[inst[20:16]];
            dest  = '0;
            value = '0;
            pc    = pc + 1'b1;   // no delay slot
            case (inst[31:26])
                op_special:
                begin
                    dest = inst[15:11];
                    case (inst[5:0])
                        fn_addu: value = a + b;
                        fn_subu: value = a - b;
                        fn_and:  value = a & b;
                        fn_or:   value = a | b;
                        fn_xor:  value = a ^ b;
                        fn_slt:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        fn_break:
                        begin
                            dest = '0;
                            stop = 1'b1;
                        end
                        default: dest = '0;
                    endcase
                end
                op_addiu:
                begin
                    dest  = inst[20:16];
                    value = a + {{16{inst[15]}}, inst[15:0]};
                end
                op_andi:
                begin
                    dest  = inst[20:16];
                    value = a & {16'h0000, inst[15:0]};
                end
                op_ori:
                begin
                    dest  = inst[20:16];
                    value = a | {16'h0000, inst[15:0]};
                end
                op_lui:
                begin
                    dest  = inst[20:16];
                    value = {inst[15:0], 16'h0000};
                end
                op_beq:  if (a == b) pc = pc + inst[imem_addr_width-1:0];
                op_bne:  if (a != b) pc = pc + inst[imem_addr_width-1:0];
                op_j:    pc = inst[imem_addr_width-1:0];
                default: ;
            endcase
            if (dest != '0)
            begin
                regs[dest] = value;
                expected_q.push_back({dest, value});
            end
            steps++;
        end
        if (!stop)
        begin
            $display("model error: %s never reaches the done instruction", name);
            other_error_count++;
        end
    endtask

    //////////////////////////////////////////////////
    // DUT sequences
    //////////////////////////////////////////////////
    task automatic reset_dut();
        @(posedge clk);
        #1;
        rst          = 1'b1;
        run          = 1'b0;
        load_valid   = 1'b0;
        retire_ready = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    task automatic load_program(input string name);
        int i;
        int waited;
        bit accepted;
        for (i = 0; i < imem_words; i++)
        begin
            load_valid = 1'b1;
            load_addr  = i[imem_addr_width-1:0];
            load_data  = prog_mem[i];
            waited     = 0;
            accepted   = 1'b0;
            while (!accepted && waited < load_timeout)
            begin
                @(negedge clk);
                accepted = load_ready;   // taken on the coming edge
                @(posedge clk);
                #1;
                waited++;
            end
            if (!accepted)
            begin
                $display("timeout: %s, load port never became ready at word %0d", name, i);
                other_error_count++;
                break;
            end
        end
        load_valid = 1'b0;
    endtask

    task automatic compare_streams(input string name, input entry_q_t want,
                                   input entry_q_t got);
        int i;
        check({name, " retire count"}, 64'(want.size()), 64'(got.size()));
        for (i = 0; i < want.size() && i < got.size(); i++)
            check($sformatf("%s retire %0d", name, i), 64'(want[i]), 64'(got[i]));
    endtask

    task automatic run_program(input string name, input bit random_ready);
        int cycles;
        int i;
        bit finished;
        reset_dut();
        load_program(name);
        run_model(name);
        run      = 1'b1;
        cycles   = 0;
        finished = 1'b0;
        actual_q.delete();
        while (!finished && cycles < run_timeout)
        begin
            @(negedge clk);
            if (done)
                finished = 1'b1;
            else
            begin
                if (retire_valid && retire_ready)
                begin
                    if (retire_reg == '0)
                    begin
                        $display("error: %s retired a write to register 0", name);
                        other_error_count++;
                    end
                    actual_q.push_back({retire_reg, retire_data});
                end
                @(posedge clk);
                #1;
                rng_state    = xorshift(rng_state);
                retire_ready = random_ready ? rng_state[0] : 1'b1;
                cycles++;
            end
        end
        if (!finished)
        begin
            $display("timeout: %s did not raise done within %0d cycles", name, run_timeout);
            other_error_count++;
        end
        else
        begin
            // core frozen after done
            for (i = 0; i < hold_cycles; i++)
            begin
                @(posedge clk);
                #1;
                retire_ready = 1'b1;
                @(negedge clk);
                check({name, " done held"}, 64'd1, 64'(done));
                check({name, " quiet after done"}, 64'd0, 64'(retire_valid));
            end
        end
        compare_streams(name, expected_q, actual_q);
    endtask

    //////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////
    task automatic test_reset_state();
        reset_dut();
        @(negedge clk);
        check("reset retire_valid", 64'd0, 64'(retire_valid));
        check("reset done", 64'd0, 64'(done));
        check("reset load_ready", 64'd1, 64'(load_ready));
    endtask

    task automatic test_alu();
        clear_program();
        prog_mem[0]  = i_format(op_lui, 0, 1, 16'h1234);
        prog_mem[1]  = i_format(op_ori, 1, 1, 16'h5678);
        prog_mem[2]  = i_format(op_addiu, 0, 2, 16'hfffb);   // -5
        prog_mem[3]  = i_format(op_addiu, 0, 3, 16'd100);
        prog_mem[4]  = r_format(fn_addu, 4, 2, 3);
        prog_mem[5]  = r_format(fn_subu, 5, 2, 3);
        prog_mem[6]  = r_format(fn_and, 6, 1, 3);
        prog_mem[7]  = r_format(fn_or, 7, 1, 2);
        prog_mem[8]  = r_format(fn_xor, 8, 1, 3);
        prog_mem[9]  = r_format(fn_slt, 9, 2, 3);
        prog_mem[10] = r_format(fn_slt, 10, 3, 2);
        prog_mem[11] = i_format(op_andi, 2, 11, 16'hff00);  // zero-extended
        prog_mem[12] = i_format(op_addiu, 0, 0, 16'd7);
        prog_mem[13] = r_format(fn_break, 0, 0, 0);
        prog_mem[14] = i_format(op_addiu, 0, 12, 16'h00c3);  // behind done
        run_program("alu", 1'b0);
    endtask

    task automatic test_forwarding();
        clear_program();
        prog_mem[0]  = i_format(op_addiu, 0, 1, 16'd1);
        prog_mem[1]  = i_format(op_addiu, 1, 1, 16'd2);
        prog_mem[2]  = r_format(fn_addu, 2, 1, 1);
        prog_mem[3]  = r_format(fn_addu, 3, 1, 2);   // distances two and one
        prog_mem[4]  = r_format(fn_subu, 4, 3, 1);
        prog_mem[5]  = r_format(fn_xor, 5, 4, 2);
        prog_mem[6]  = r_format(fn_or, 6, 5, 4);
        prog_mem[7]  = r_format(fn_slt, 7, 6, 3);
        prog_mem[8]  = r_format(fn_addu, 1, 7, 1);
        prog_mem[9]  = i_format(op_andi, 1, 8, 16'h000f);
        prog_mem[10] = r_format(fn_break, 0, 0, 0);
        run_program("forwarding", 1'b0);
    endtask

    task automatic test_branches();
        clear_program();
        prog_mem[0]  = i_format(op_addiu, 0, 1, 16'd5);
        prog_mem[1]  = i_format(op_addiu, 0, 2, 16'd5);
        prog_mem[2]  = i_format(op_beq, 1, 2, 16'd2);      // taken
        prog_mem[3]  = i_format(op_addiu, 0, 3, 16'h0033);
        prog_mem[4]  = i_format(op_addiu, 0, 4, 16'h0044);
        prog_mem[5]  = i_format(op_bne, 1, 2, 16'd1);      // falls through
        prog_mem[6]  = i_format(op_addiu, 0, 5, 16'h0055);
        prog_mem[7]  = i_format(op_bne, 1, 0, 16'd2);      // taken
        prog_mem[8]  = i_format(op_addiu, 0, 6, 16'h0066);
        prog_mem[9]  = i_format(op_addiu, 0, 7, 16'h0077);
        prog_mem[10] = i_format(op_beq, 1, 0, 16'd1);      // falls through
        prog_mem[11] = j_format(26'd14);
        prog_mem[12] = i_format(op_addiu, 0, 8, 16'h0088);
        prog_mem[13] = i_format(op_addiu, 0, 9, 16'h0099);
        prog_mem[14] = i_format(op_addiu, 0, 10, 16'h010a);
        prog_mem[15] = r_format(fn_break, 0, 0, 0);
        run_program("branches", 1'b0);
    endtask

    task automatic test_backpressure();
        clear_program();
        prog_mem[0] = i_format(op_addiu, 0, 1, 16'd0);
        prog_mem[1] = i_format(op_addiu, 0, 2, 16'd6);
        prog_mem[2] = i_format(op_addiu, 1, 1, 16'd3);     // loop body
        prog_mem[3] = r_format(fn_addu, 3, 3, 1);
        prog_mem[4] = i_format(op_addiu, 2, 2, 16'hffff);
        prog_mem[5] = i_format(op_bne, 2, 0, 16'hfffc);    // back to 2
        prog_mem[6] = r_format(fn_xor, 4, 3, 1);
        prog_mem[7] = i_format(op_addiu, 0, 0, 16'd1);
        prog_mem[8] = r_format(fn_break, 0, 0, 0);
        run_program("loop ready high", 1'b0);
        reference_q = actual_q;
        run_program("loop ready random", 1'b1);
        compare_streams("random against steady", reference_q, actual_q);
    endtask

    initial
    begin
        rst               = 1'b1;
        run               = 1'b0;
        load_valid        = 1'b0;
        load_addr         = '0;
        load_data         = '0;
        retire_ready      = 1'b1;
        rng_state         = 32'd32449;
        check_count       = 0;
        mismatch_count    = 0;
        other_error_count = 0;

        test_reset_state();
        test_alu();
        test_forwarding();
        test_branches();
        test_backpressure();

        $display("checks: %0d, mismatches: %0d, other errors: %0d",
                 check_count, mismatch_count, other_error_count);
        if (mismatch_count == 0 && other_error_count == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* mips_cpu.f */
source/mips_pkg.sv
source/fetch_unit.sv
source/decoder.sv
source/register_file.sv
source/forwarding_unit.sv
source/execution.sv
source/pipeline_stage.sv
source/pipeline_control.sv
source/mips_cpu.sv
tb/mips_cpu_props.sv
tb/tb_mips_cpu.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_mips_cpu
FILELIST := mips_cpu.f
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@! grep -q "Simulation failed" $(LOG)
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
